// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= rs_cluster_tb
FILELIST  ?= rs_cluster.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  := All tests passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: hw/rs_cluster.sv
module rs_cluster (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush,
    input  rs_pkg::rs_dispatch_t  dispatch,
    input  logic                  dispatch_valid,
    input  rs_pkg::cdb_t          cdb [rs_pkg::NUM_CDB],
    input  logic                  alu_ready,
    input  logic                  mul_ready,
    input  logic                  div_ready,
    output logic                  alu_issue_valid,
    output logic                  mul_issue_valid,
    output logic                  div_issue_valid,
    output rs_pkg::rs_issue_t     alu_issue,
    output rs_pkg::rs_issue_t     mul_issue,
    output rs_pkg::rs_issue_t     div_issue,
    output logic                  alu_full,
    output logic                  mul_full,
    output logic                  div_full
);

    logic alu_write;
    logic mul_write;
    logic div_write;

    // steer by unit field
    assign alu_write = dispatch_valid && (dispatch.unit == rs_pkg::unit_alu);
    assign mul_write = dispatch_valid && (dispatch.unit == rs_pkg::unit_mul);
    assign div_write = dispatch_valid && (dispatch.unit == rs_pkg::unit_div);

    rs_station #(
        .DEPTH        (rs_pkg::ALU_DEPTH),
        .OLDEST_FIRST (1'b1)
    ) i_alu_station (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .write       (alu_write),
        .dispatch    (dispatch),
        .cdb         (cdb),
        .ready       (alu_ready),
        .issue_valid (alu_issue_valid),
        .issue       (alu_issue),
        .full        (alu_full)
    );

    rs_station #(
        .DEPTH        (rs_pkg::MUL_DEPTH),
        .OLDEST_FIRST (1'b0)
    ) i_mul_station (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .write       (mul_write),
        .dispatch    (dispatch),
        .cdb         (cdb),
        .ready       (mul_ready),
        .issue_valid (mul_issue_valid),
        .issue       (mul_issue),
        .full        (mul_full)
    );

    rs_station #(
        .DEPTH        (rs_pkg::DIV_DEPTH),
        .OLDEST_FIRST (1'b0)
    ) i_div_station (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .write       (div_write),
        .dispatch    (dispatch),
        .cdb         (cdb),
        .ready       (div_ready),
        .issue_valid (div_issue_valid),
        .issue       (div_issue),
        .full        (div_full)
    );

endmodule

// File: hw/rs_issue_select.sv
module rs_issue_select #(
    parameter int DEPTH        = 4,
    parameter bit OLDEST_FIRST = 1'b1
) (
    input  rs_pkg::rs_entry_t         entries [DEPTH],
    input  logic                      ready,
    input  logic                      flush,
    output logic                      issue_valid,
    output logic [$clog2(DEPTH)-1:0]  issue_index
);

    localparam int IDX_W = $clog2(DEPTH);

    logic [DEPTH-1:0]              entry_ready;
    logic                          any_ready;
    logic [rs_pkg::AGE_WIDTH-1:0]  best_age;

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            entry_ready[i] = entries[i].busy && entries[i].ps1_valid && entries[i].ps2_valid;
        end
    end

    always_comb begin
        any_ready   = 1'b0;
        best_age    = '1;
        issue_index = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (entry_ready[i]) begin
                if (OLDEST_FIRST) begin
                    // strict compare keeps the lower index on a tie
                    if (!any_ready || entries[i].age < best_age) begin
                        best_age    = entries[i].age;
                        issue_index = IDX_W'(i);
                    end
                end else if (!any_ready) begin
                    issue_index = IDX_W'(i);
                end
                any_ready = 1'b1;
            end
        end
    end

    // unit back-pressure and flush both hold the entry
    assign issue_valid = any_ready && ready && !flush;

endmodule

// File: hw/rs_pkg.sv
package rs_pkg;

    // physical register tag and reorder buffer index
    localparam int PR_WIDTH  = 6;
    localparam int ROB_WIDTH = 5;
    localparam int OP_WIDTH  = 4;

    // dispatch stamp, smaller is older
    localparam int AGE_WIDTH = 8;

    localparam int ALU_DEPTH = 4;
    localparam int MUL_DEPTH = 2;
    localparam int DIV_DEPTH = 2;

    // broadcast order is alu, mul, div, load
    localparam int NUM_CDB = 4;

    typedef enum logic [1:0] {
        unit_alu,
        unit_mul,
        unit_div
    } rs_unit_e;

    typedef struct packed {
        rs_unit_e              unit;
        logic [PR_WIDTH-1:0]   ps1;
        logic                  ps1_valid;
        logic [PR_WIDTH-1:0]   ps2;
        logic                  ps2_valid;
        logic [PR_WIDTH-1:0]   pd;
        logic [ROB_WIDTH-1:0]  rob_id;
        logic [OP_WIDTH-1:0]   op;
        logic [AGE_WIDTH-1:0]  age;
    } rs_dispatch_t;

    typedef struct packed {
        logic                  busy;
        logic [PR_WIDTH-1:0]   ps1;
        logic                  ps1_valid;
        logic [PR_WIDTH-1:0]   ps2;
        logic                  ps2_valid;
        logic [PR_WIDTH-1:0]   pd;
        logic [ROB_WIDTH-1:0]  rob_id;
        logic [OP_WIDTH-1:0]   op;
        logic [AGE_WIDTH-1:0]  age;
    } rs_entry_t;

    // what the functional unit sees
    typedef struct packed {
        logic [PR_WIDTH-1:0]   ps1;
        logic [PR_WIDTH-1:0]   ps2;
        logic [PR_WIDTH-1:0]   pd;
        logic [ROB_WIDTH-1:0]  rob_id;
        logic [OP_WIDTH-1:0]   op;
    } rs_issue_t;

    typedef struct packed {
        logic                  valid;
        logic [PR_WIDTH-1:0]   pd;
    } cdb_t;

endpackage

// File: hw/rs_station.sv
module rs_station #(
    parameter int DEPTH        = 4,
    parameter bit OLDEST_FIRST = 1'b1
) (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  flush,
    input  logic                  write,
    input  rs_pkg::rs_dispatch_t  dispatch,
    input  rs_pkg::cdb_t          cdb [rs_pkg::NUM_CDB],
    input  logic                  ready,
    output logic                  issue_valid,
    output rs_pkg::rs_issue_t     issue,
    output logic                  full
);

    localparam int IDX_W = $clog2(DEPTH);

    rs_pkg::rs_entry_t  entries [DEPTH];

    logic [DEPTH-1:0]  busy;
    logic [DEPTH-1:0]  src1_hit;
    logic [DEPTH-1:0]  src2_hit;
    logic              incoming_src1_hit;
    logic              incoming_src2_hit;
    logic [IDX_W-1:0]  alloc_index;
    logic [IDX_W-1:0]  issue_index;
    logic              alloc_found;

    rs_wakeup #(
        .DEPTH (DEPTH)
    ) i_wakeup (
        .entries           (entries),
        .incoming          (dispatch),
        .cdb               (cdb),
        .src1_hit          (src1_hit),
        .src2_hit          (src2_hit),
        .incoming_src1_hit (incoming_src1_hit),
        .incoming_src2_hit (incoming_src2_hit)
    );

    rs_issue_select #(
        .DEPTH        (DEPTH),
        .OLDEST_FIRST (OLDEST_FIRST)
    ) i_select (
        .entries     (entries),
        .ready       (ready),
        .flush       (flush),
        .issue_valid (issue_valid),
        .issue_index (issue_index)
    );

    always_comb begin
        for (int i = 0; i < DEPTH; i++) begin
            busy[i] = entries[i].busy;
        end
    end

    assign full = &busy;

    // lowest free slot, from the busy bits before this edge
    always_comb begin
        alloc_found = 1'b0;
        alloc_index = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (!busy[i] && !alloc_found) begin
                alloc_found = 1'b1;
                alloc_index = IDX_W'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            for (int i = 0; i < DEPTH; i++) begin
                entries[i].busy <= 1'b0;
            end
        end else begin
            for (int i = 0; i < DEPTH; i++) begin
                if (src1_hit[i]) begin
                    entries[i].ps1_valid <= 1'b1;
                end
                if (src2_hit[i]) begin
                    entries[i].ps2_valid <= 1'b1;
                end
            end

            if (issue_valid) begin
                entries[issue_index].busy <= 1'b0;
            end

            // target slot is free, so it never collides with the issued one
            if (write && alloc_found) begin
                entries[alloc_index] <= '{
                    busy:      1'b1,
                    ps1:       dispatch.ps1,
                    ps1_valid: dispatch.ps1_valid || incoming_src1_hit,
                    ps2:       dispatch.ps2,
                    ps2_valid: dispatch.ps2_valid || incoming_src2_hit,
                    pd:        dispatch.pd,
                    rob_id:    dispatch.rob_id,
                    op:        dispatch.op,
                    age:       dispatch.age
                };
            end
        end
    end

    always_comb begin
        issue.ps1    = entries[issue_index].ps1;
        issue.ps2    = entries[issue_index].ps2;
        issue.pd     = entries[issue_index].pd;
        issue.rob_id = entries[issue_index].rob_id;
        issue.op     = entries[issue_index].op;
    end

endmodule

// File: hw/rs_wakeup.sv
module rs_wakeup #(
    parameter int DEPTH = 4
) (
    input  rs_pkg::rs_entry_t    entries [DEPTH],
    input  rs_pkg::rs_dispatch_t incoming,
    input  rs_pkg::cdb_t         cdb [rs_pkg::NUM_CDB],
    output logic [DEPTH-1:0]     src1_hit,
    output logic [DEPTH-1:0]     src2_hit,
    output logic                 incoming_src1_hit,
    output logic                 incoming_src2_hit
);

    // stored entries, only busy ones can wake
    always_comb begin
        src1_hit = '0;
        src2_hit = '0;
        for (int b = 0; b < rs_pkg::NUM_CDB; b++) begin
            if (cdb[b].valid) begin
                for (int i = 0; i < DEPTH; i++) begin
                    if (entries[i].busy) begin
                        if (entries[i].ps1 == cdb[b].pd) begin
                            src1_hit[i] = 1'b1;
                        end
                        if (entries[i].ps2 == cdb[b].pd) begin
                            src2_hit[i] = 1'b1;
                        end
                    end
                end
            end
        end
    end

    // instruction arriving this cycle, so a same-cycle broadcast is not lost
    always_comb begin
        incoming_src1_hit = 1'b0;
        incoming_src2_hit = 1'b0;
        for (int b = 0; b < rs_pkg::NUM_CDB; b++) begin
            if (cdb[b].valid && incoming.ps1 == cdb[b].pd) begin
                incoming_src1_hit = 1'b1;
            end
            if (cdb[b].valid && incoming.ps2 == cdb[b].pd) begin
                incoming_src2_hit = 1'b1;
            end
        end
    end

endmodule

// File: rs_cluster.f
hw/rs_pkg.sv
hw/rs_wakeup.sv
hw/rs_issue_select.sv
hw/rs_station.sv
hw/rs_cluster.sv
sim/rs_cluster_asserts.sv
sim/rs_cluster_tb.sv

// File: sim/rs_cluster_asserts.sv
module rs_cluster_asserts (
    input logic clk,
    input logic reset,
    input logic flush,
    input logic write,
    input logic full,
    input logic issue_valid
);

    timeunit 1ns;
    timeprecision 1ps;

    // decode must hold off on a full station
    write_while_full: assert property (@(posedge clk) disable iff (reset) !(write && full))
        else $error("dispatch written into a full station");

    // station is empty the cycle after a flush
    flush_empties: assert property (@(posedge clk) disable iff (reset)
        flush |=> !full && !issue_valid)
        else $error("station not empty after flush");

    // issuing from a full station frees a slot at that edge
    issue_frees_slot: assert property (@(posedge clk) disable iff (reset)
        issue_valid && full |=> !full)
        else $error("issue from a full station did not free a slot");

endmodule

bind rs_station rs_cluster_asserts i_asserts (
    .clk         (clk),
    .reset       (reset),
    .flush       (flush),
    .write       (write),
    .full        (full),
    .issue_valid (issue_valid)
);

// File: sim/rs_cluster_tb.sv
module rs_cluster_tb;

    timeunit 1ns;
    timeprecision 1ps;

    // index 0 alu, 1 mul, 2 div
    typedef struct packed {
        rs_pkg::rs_dispatch_t         disp;
        logic                         dv;
        rs_pkg::cdb_t [3:0]           cdb;
        logic [2:0]                   ready;
        logic                         flush;
        logic [2:0]                   exp_valid;
        rs_pkg::rs_issue_t [2:0]      exp_issue;
        logic [2:0]                   exp_full;
    } row_t;

    logic                  clk;
    logic                  reset;
    logic                  flush;
    rs_pkg::rs_dispatch_t  dispatch;
    logic                  dispatch_valid;
    rs_pkg::cdb_t          cdb [rs_pkg::NUM_CDB];
    logic                  alu_ready;
    logic                  mul_ready;
    logic                  div_ready;
    logic                  alu_issue_valid;
    logic                  mul_issue_valid;
    logic                  div_issue_valid;
    rs_pkg::rs_issue_t     alu_issue;
    rs_pkg::rs_issue_t     mul_issue;
    rs_pkg::rs_issue_t     div_issue;
    logic                  alu_full;
    logic                  mul_full;
    logic                  div_full;

    row_t                  rows [$];
    row_t                  cur;
    rs_pkg::rs_dispatch_t  held [4];
    logic [7:0]            age_ctr;
    int                    errors;
    int                    checks;
    int                    wait_cycles;

    rs_cluster i_dut (
        .clk             (clk),
        .reset           (reset),
        .flush           (flush),
        .dispatch        (dispatch),
        .dispatch_valid  (dispatch_valid),
        .cdb             (cdb),
        .alu_ready       (alu_ready),
        .mul_ready       (mul_ready),
        .div_ready       (div_ready),
        .alu_issue_valid (alu_issue_valid),
        .mul_issue_valid (mul_issue_valid),
        .div_issue_valid (div_issue_valid),
        .alu_issue       (alu_issue),
        .mul_issue       (mul_issue),
        .div_issue       (div_issue),
        .alu_full        (alu_full),
        .mul_full        (mul_full),
        .div_full        (div_full)
    );

    always #4 clk = ~clk;

    // age below zero takes the running stamp
    function automatic rs_pkg::rs_dispatch_t instr(int u, int ps1, bit v1, int ps2, bit v2,
                                                   int age);
        rs_pkg::rs_dispatch_t d;
        d.unit      = rs_pkg::rs_unit_e'(u);
        d.ps1       = 6'(ps1);
        d.ps1_valid = v1;
        d.ps2       = 6'(ps2);
        d.ps2_valid = v2;
        d.rob_id    = 5'($urandom);
        d.pd        = 6'($urandom);
        d.op        = 4'($urandom);
        if (age < 0) begin
            d.age   = age_ctr;
            age_ctr = age_ctr + 8'd1;
        end else begin
            d.age = 8'(age);
        end
        return d;
    endfunction

    function automatic rs_pkg::rs_issue_t to_issue(rs_pkg::rs_dispatch_t d);
        rs_pkg::rs_issue_t s;
        s.ps1    = d.ps1;
        s.ps2    = d.ps2;
        s.pd     = d.pd;
        s.rob_id = d.rob_id;
        s.op     = d.op;
        return s;
    endfunction

    task automatic begin_row();
        cur       = '0;
        cur.ready = 3'b111;
    endtask

    task automatic end_row();
        rows.push_back(cur);
    endtask

    task automatic dispatch_row(rs_pkg::rs_dispatch_t d, logic [2:0] rdy);
        begin_row();
        cur.disp  = d;
        cur.dv    = 1'b1;
        cur.ready = rdy;
        end_row();
    endtask

    task automatic expect_row(int u, rs_pkg::rs_dispatch_t d, logic [2:0] fl);
        begin_row();
        cur.exp_valid[u] = 1'b1;
        cur.exp_issue[u] = to_issue(d);
        cur.exp_full     = fl;
        end_row();
    endtask

    task automatic build_table();
        rs_pkg::rs_dispatch_t d;
        for (int u = 0; u < 3; u++) begin
            d = instr(u, 1, 1'b1, 2, 1'b1, -1);
            dispatch_row(d, 3'b111);
            expect_row(u, d, 3'b000);
            begin_row();
            end_row();
        end
        // wakeup, one bus per unit
        for (int u = 0; u < 3; u++) begin
            d = instr(u, 40 + u, 1'b0, 2, 1'b1, -1);
            dispatch_row(d, 3'b111);
            begin_row();
            end_row();
            begin_row();
            cur.cdb[u] = '{valid: 1'b1, pd: 6'(40 + u)};
            end_row();
            expect_row(u, d, 3'b000);
        end
        // load bus in the dispatch cycle
        d = instr(0, 43, 1'b0, 2, 1'b1, -1);
        begin_row();
        cur.disp   = d;
        cur.dv     = 1'b1;
        cur.cdb[3] = '{valid: 1'b1, pd: 6'd43};
        end_row();
        expect_row(0, d, 3'b000);
        // alu oldest first, ages out of index order
        held[0] = instr(0, 1, 1'b1, 2, 1'b1, 30);
        held[1] = instr(0, 1, 1'b1, 2, 1'b1, 10);
        held[2] = instr(0, 1, 1'b1, 2, 1'b1, 20);
        for (int k = 0; k < 3; k++) begin
            dispatch_row(held[k], 3'b110);
        end
        expect_row(0, held[1], 3'b000);
        expect_row(0, held[2], 3'b000);
        expect_row(0, held[0], 3'b000);
        begin_row();
        end_row();
        // mul lowest index, the younger one sits in slot 0
        held[0] = instr(1, 1, 1'b1, 2, 1'b1, 60);
        held[1] = instr(1, 1, 1'b1, 2, 1'b1, 50);
        dispatch_row(held[0], 3'b101);
        dispatch_row(held[1], 3'b101);
        expect_row(1, held[0], 3'b010);
        expect_row(1, held[1], 3'b000);
        // div back-pressure
        d = instr(2, 1, 1'b1, 2, 1'b1, -1);
        dispatch_row(d, 3'b011);
        begin_row();
        cur.ready = 3'b011;
        end_row();
        begin_row();
        cur.ready = 3'b011;
        end_row();
        expect_row(2, d, 3'b000);
        begin_row();
        end_row();
        // alu full, then release one
        for (int k = 0; k < 4; k++) begin
            held[k] = instr(0, 50 + k, 1'b0, 2, 1'b1, -1);
            dispatch_row(held[k], 3'b111);
        end
        begin_row();
        cur.exp_full = 3'b001;
        end_row();
        begin_row();
        cur.cdb[0]   = '{valid: 1'b1, pd: 6'd51};
        cur.exp_full = 3'b001;
        end_row();
        expect_row(0, held[1], 3'b001);
        begin_row();
        end_row();
        // flush with entries present
        dispatch_row(instr(1, 1, 1'b1, 2, 1'b1, -1), 3'b101);
        dispatch_row(instr(1, 1, 1'b1, 2, 1'b1, -1), 3'b101);
        begin_row();
        cur.flush    = 1'b1;
        cur.exp_full = 3'b010;
        end_row();
        begin_row();
        end_row();
        begin_row();
        cur.cdb[0] = '{valid: 1'b1, pd: 6'd50};
        cur.cdb[1] = '{valid: 1'b1, pd: 6'd52};
        cur.cdb[2] = '{valid: 1'b1, pd: 6'd53};
        end_row();
        begin_row();
        end_row();
    endtask

    task automatic apply_row(row_t r);
        dispatch       = r.disp;
        dispatch_valid = r.dv;
        for (int b = 0; b < rs_pkg::NUM_CDB; b++) begin
            cdb[b] = r.cdb[b];
        end
        alu_ready = r.ready[0];
        mul_ready = r.ready[1];
        div_ready = r.ready[2];
        flush     = r.flush;
    endtask

    task automatic check_row(int idx, row_t r);
        logic [2:0]         gv;
        logic [2:0]         gf;
        rs_pkg::rs_issue_t  gi [3];
        string              names [3];
        names = '{"alu", "mul", "div"};
        gv    = {div_issue_valid, mul_issue_valid, alu_issue_valid};
        gf    = {div_full, mul_full, alu_full};
        gi    = '{alu_issue, mul_issue, div_issue};
        for (int u = 0; u < 3; u++) begin
            checks++;
            if (gv[u] !== r.exp_valid[u]) begin
                errors++;
                $display("Fail at %0t row %0d: %s_issue_valid expected %0b got %0b",
                         $time, idx, names[u], r.exp_valid[u], gv[u]);
            end
            if (gf[u] !== r.exp_full[u]) begin
                errors++;
                $display("Fail at %0t row %0d: %s_full expected %0b got %0b",
                         $time, idx, names[u], r.exp_full[u], gf[u]);
            end
            if (r.exp_valid[u] && gi[u] !== r.exp_issue[u]) begin
                errors++;
                $display("Fail at %0t row %0d: %s_issue expected %h got %h",
                         $time, idx, names[u], r.exp_issue[u], gi[u]);
            end
        end
    endtask

    initial begin
        #20000;
        $display("timeout: the stimulus loop did not finish");
        $display("Some tests failed");
        $finish;
    end

    initial begin
        void'($urandom(32'hcffd6373));
        errors  = 0;
        checks  = 0;
        age_ctr = 8'd100;
        clk     = 1'b0;
        reset   = 1'b1;
        apply_row('0);
        build_table();
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        wait_cycles = 0;
        while ((alu_full || mul_full || div_full || alu_issue_valid || mul_issue_valid ||
                div_issue_valid) && wait_cycles < 10) begin
            @(negedge clk);
            wait_cycles++;
        end
        if (wait_cycles >= 10) begin
            errors++;
            $display("outputs did not go idle after reset");
        end
        for (int i = 0; i < rows.size(); i++) begin
            apply_row(rows[i]);
            #3;
            check_row(i, rows[i]);
            @(negedge clk);
        end
        $display("rows: %0d checks: %0d errors: %0d", rows.size(), checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule
